// File: source/arch_defs_pkg.sv
package arch_defs_pkg;

    // ====================
    // Word and status layout
    // ====================
    localparam int DATA_WIDTH            = 8;  // Bits per UART word
    localparam int STATUS_WIDTH          = 1;
    localparam int STATUS_FRAME_ERROR_BIT = 0; // Low stop bit seen

    // ====================
    // State encodings
    // ====================
    typedef enum logic [2:0] {
        S_UART_RX_IDLE,
        S_UART_RX_VALIDATE_START, // Confirm start bit at mid-bit
        S_UART_RX_READ_DATA,
        S_UART_RX_STOP,
        S_UART_RX_DATA_READY      // Hold word until the FIFO takes it
    } uart_fsm_state_t;

    typedef enum logic [1:0] {
        S_UART_TX_IDLE,
        S_UART_TX_START,
        S_UART_TX_DATA,
        S_UART_TX_STOP
    } uart_tx_state_t;

endpackage

// File: source/uart_receiver.sv
module uart_receiver #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16,
    parameter int WORD_SIZE         = arch_defs_pkg::DATA_WIDTH
) (
    input  logic clk,
    input  logic reset,

    input  logic rx_serial_in_data,
    input  logic cpu_read_data_ack_pulse,

    output logic                                 rx_strobe_data_ready_level,
    output logic [WORD_SIZE-1:0]                 rx_parallel_data_out,
    output logic [arch_defs_pkg::STATUS_WIDTH-1:0] rx_status_reg
);

    localparam int CYCLES_PER_SAMPLE   = CLOCK_SPEED / (BAUD_RATE * OVERSAMPLING_RATE);
    localparam int TIMER_SIZE          = $clog2(CYCLES_PER_SAMPLE + 1);
    localparam int SAMPLE_COUNTER_SIZE = $clog2(OVERSAMPLING_RATE);
    localparam int DATA_COUNTER_SIZE   = $clog2(WORD_SIZE);
    localparam logic SIGNAL_IDLE       = 1'b1;
    localparam logic SIGNAL_START_BIT  = 1'b0;

    logic [WORD_SIZE-1:0]                   rx_shift_reg;
    logic [arch_defs_pkg::STATUS_WIDTH-1:0] status_reg;
    logic                                   data_ready_flag;

    assign rx_parallel_data_out       = rx_shift_reg;
    assign rx_status_reg              = status_reg;
    assign rx_strobe_data_ready_level = data_ready_flag;

    // ====================
    // Synchronizer
    // ====================
    logic sync_ff1;
    logic synced_serial_in;
    logic synced_prev;       // Previous synced value for edge detect
    logic start_edge;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_ff1         <= SIGNAL_IDLE;
            synced_serial_in <= SIGNAL_IDLE;
            synced_prev      <= SIGNAL_IDLE;
        end else begin
            sync_ff1         <= rx_serial_in_data;
            synced_serial_in <= sync_ff1;
            synced_prev      <= synced_serial_in;
        end
    end

    // Only a falling edge starts a frame, so a line stuck low after a bad
    // stop bit is not taken for a new start bit
    assign start_edge = (synced_prev == SIGNAL_IDLE) && (synced_serial_in == SIGNAL_START_BIT);

    // ====================
    // Control unit
    // ====================
    arch_defs_pkg::uart_fsm_state_t current_state, next_state;
    logic [DATA_COUNTER_SIZE-1:0]   bit_count, next_bit_count;

    logic cmd_enable_internal_timer;
    logic cmd_reset_counters;
    logic cmd_latch_serial_input;
    logic cmd_flag_frame_error;
    logic cmd_clear_status_reg;
    logic cmd_set_data_ready_flag;
    logic cmd_clear_data_ready_flag;
    logic event_middle_of_bit;
    logic event_end_of_bit;

    always_comb begin
        next_state                = current_state;
        next_bit_count            = bit_count;
        cmd_enable_internal_timer = 1'b0;
        cmd_reset_counters        = 1'b0;
        cmd_latch_serial_input    = 1'b0;
        cmd_flag_frame_error      = 1'b0;
        cmd_clear_status_reg      = 1'b0;
        cmd_set_data_ready_flag   = 1'b0;
        cmd_clear_data_ready_flag = 1'b0;

        case (current_state)
            arch_defs_pkg::S_UART_RX_IDLE: begin
                if (start_edge) begin
                    next_state           = arch_defs_pkg::S_UART_RX_VALIDATE_START;
                    next_bit_count       = '0;
                    cmd_reset_counters   = 1'b1;
                    cmd_clear_status_reg = 1'b1;
                end
            end
            arch_defs_pkg::S_UART_RX_VALIDATE_START: begin
                cmd_enable_internal_timer = 1'b1;
                if (event_middle_of_bit) begin
                    if (synced_serial_in == SIGNAL_START_BIT) begin
                        next_state         = arch_defs_pkg::S_UART_RX_READ_DATA;
                        cmd_reset_counters = 1'b1; // Realign to mid-bit
                    end else begin
                        next_state = arch_defs_pkg::S_UART_RX_IDLE; // Glitch
                    end
                end
            end
            arch_defs_pkg::S_UART_RX_READ_DATA: begin
                cmd_enable_internal_timer = 1'b1;
                if (event_end_of_bit) begin
                    cmd_latch_serial_input = 1'b1;
                    next_bit_count         = bit_count + 1'b1;
                    if (bit_count == DATA_COUNTER_SIZE'(WORD_SIZE - 1)) begin
                        next_state     = arch_defs_pkg::S_UART_RX_STOP;
                        next_bit_count = '0;
                    end
                end
            end
            arch_defs_pkg::S_UART_RX_STOP: begin
                cmd_enable_internal_timer = 1'b1;
                if (event_end_of_bit) begin
                    if (synced_serial_in == SIGNAL_IDLE) begin
                        next_state              = arch_defs_pkg::S_UART_RX_DATA_READY;
                        cmd_set_data_ready_flag = 1'b1;
                    end else begin
                        next_state           = arch_defs_pkg::S_UART_RX_IDLE;
                        cmd_flag_frame_error = 1'b1;
                    end
                end
            end
            arch_defs_pkg::S_UART_RX_DATA_READY: begin
                if (cpu_read_data_ack_pulse) begin
                    next_state                = arch_defs_pkg::S_UART_RX_IDLE;
                    cmd_clear_data_ready_flag = 1'b1;
                end
            end
            default: next_state = arch_defs_pkg::S_UART_RX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_state   <= arch_defs_pkg::S_UART_RX_IDLE;
            bit_count       <= '0;
            status_reg      <= '0;
            data_ready_flag <= 1'b0;
        end else begin
            current_state <= next_state;
            bit_count     <= next_bit_count;
            if (cmd_clear_status_reg)
                status_reg <= '0;
            else if (cmd_flag_frame_error)
                status_reg[arch_defs_pkg::STATUS_FRAME_ERROR_BIT] <= 1'b1;
            if (cmd_set_data_ready_flag)
                data_ready_flag <= 1'b1;
            else if (cmd_clear_data_ready_flag)
                data_ready_flag <= 1'b0;
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (cmd_latch_serial_input)
            rx_shift_reg <= {synced_serial_in, rx_shift_reg[WORD_SIZE-1:1]};
    end

    // ====================
    // Oversample counter
    // ====================
    logic [TIMER_SIZE-1:0]          internal_timer;
    logic [SAMPLE_COUNTER_SIZE-1:0] sample_count;
    logic                           cmd_inc_sample_count;

    assign cmd_inc_sample_count = cmd_enable_internal_timer &&
                                  (internal_timer == TIMER_SIZE'(CYCLES_PER_SAMPLE - 1));

    always_ff @(posedge clk) begin
        if (reset || cmd_reset_counters) begin
            internal_timer      <= '0;
            sample_count        <= '0;
            event_middle_of_bit <= 1'b0;
            event_end_of_bit    <= 1'b0;
        end else begin
            if (cmd_inc_sample_count) begin
                internal_timer <= '0;
                if (sample_count == SAMPLE_COUNTER_SIZE'(OVERSAMPLING_RATE - 1))
                    sample_count <= '0;
                else
                    sample_count <= sample_count + 1'b1;
            end else if (cmd_enable_internal_timer) begin
                internal_timer <= internal_timer + 1'b1;
            end
            event_middle_of_bit <= cmd_inc_sample_count &&
                (sample_count == SAMPLE_COUNTER_SIZE'(OVERSAMPLING_RATE / 2 - 1));
            event_end_of_bit    <= cmd_inc_sample_count &&
                (sample_count == SAMPLE_COUNTER_SIZE'(OVERSAMPLING_RATE - 1));
        end
    end

endmodule

// File: source/uart_transmitter.sv
module uart_transmitter #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16,
    parameter int WORD_SIZE         = arch_defs_pkg::DATA_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tx_word_available_i,
    input  logic [WORD_SIZE-1:0] tx_word_i,
    output logic                 tx_take_word_o,
    output logic                 tx_serial_out_o,
    output logic                 tx_busy_o
);

    // Same bit period as the receiver sees
    localparam int CYCLES_PER_SAMPLE = CLOCK_SPEED / (BAUD_RATE * OVERSAMPLING_RATE);
    localparam int CYCLES_PER_BIT    = CYCLES_PER_SAMPLE * OVERSAMPLING_RATE;
    localparam int BIT_TIMER_SIZE    = $clog2(CYCLES_PER_BIT + 1);
    localparam int INDEX_SIZE        = $clog2(WORD_SIZE);

    arch_defs_pkg::uart_tx_state_t state;
    logic [BIT_TIMER_SIZE-1:0]     bit_timer;
    logic [INDEX_SIZE-1:0]         bit_index;
    logic [WORD_SIZE-1:0]          shift_reg;
    logic                          serial_q;
    logic                          bit_done;

    assign bit_done  = (bit_timer == BIT_TIMER_SIZE'(CYCLES_PER_BIT - 1));
    assign tx_busy_o = (state != arch_defs_pkg::S_UART_TX_IDLE);
    assign tx_serial_out_o = serial_q;

    // Take a word when idle, or at the end of a stop bit for back to back frames
    assign tx_take_word_o = tx_word_available_i &&
                            ((state == arch_defs_pkg::S_UART_TX_IDLE) ||
                             (state == arch_defs_pkg::S_UART_TX_STOP && bit_done));

    // ====================
    // Frame sequencer
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= arch_defs_pkg::S_UART_TX_IDLE;
            bit_timer <= '0;
            bit_index <= '0;
            serial_q  <= 1'b1;  // Line idles high
        end else begin
            bit_timer <= bit_done ? '0 : bit_timer + 1'b1;
            case (state)
                arch_defs_pkg::S_UART_TX_IDLE: begin
                    bit_timer <= '0;
                    if (tx_take_word_o) begin
                        state    <= arch_defs_pkg::S_UART_TX_START;
                        serial_q <= 1'b0;
                    end
                end
                arch_defs_pkg::S_UART_TX_START: begin
                    if (bit_done) begin
                        state     <= arch_defs_pkg::S_UART_TX_DATA;
                        bit_index <= '0;
                        serial_q  <= shift_reg[0];
                    end
                end
                arch_defs_pkg::S_UART_TX_DATA: begin
                    if (bit_done) begin
                        if (bit_index == INDEX_SIZE'(WORD_SIZE - 1)) begin
                            state    <= arch_defs_pkg::S_UART_TX_STOP;
                            serial_q <= 1'b1;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                            serial_q  <= shift_reg[1];
                        end
                    end
                end
                arch_defs_pkg::S_UART_TX_STOP: begin
                    if (bit_done) begin
                        if (tx_take_word_o) begin
                            state    <= arch_defs_pkg::S_UART_TX_START;
                            serial_q <= 1'b0;
                        end else begin
                            state <= arch_defs_pkg::S_UART_TX_IDLE;
                        end
                    end
                end
                default: begin
                    state    <= arch_defs_pkg::S_UART_TX_IDLE;
                    serial_q <= 1'b1;
                end
            endcase
        end
    end

    // Payload shifter, LSB goes out first
    always_ff @(posedge clk) begin
        if (tx_take_word_o)
            shift_reg <= tx_word_i;
        else if (state == arch_defs_pkg::S_UART_TX_DATA && bit_done)
            shift_reg <= {1'b0, shift_reg[WORD_SIZE-1:1]};
    end

endmodule

// File: source/word_fifo.sv
module word_fifo #(
    parameter int WIDTH = arch_defs_pkg::DATA_WIDTH,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             write_i,
    input  logic [WIDTH-1:0] write_data_i,
    input  logic             read_i,
    output logic [WIDTH-1:0] read_data_o,
    output logic             write_accept_o,
    output logic             not_empty_o,
    output logic             full_o
);

    localparam int PTR_SIZE   = $clog2(DEPTH);
    localparam int COUNT_SIZE = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [PTR_SIZE-1:0]   write_ptr;
    logic [PTR_SIZE-1:0]   read_ptr;
    logic [COUNT_SIZE-1:0] count;
    logic                  do_write;
    logic                  do_read;

    // ====================
    // Handshake
    // ====================
    assign full_o         = (count == COUNT_SIZE'(DEPTH));
    assign not_empty_o    = (count != '0);
    assign do_write       = write_i && !full_o;
    assign do_read        = read_i && not_empty_o;
    assign write_accept_o = do_write;     // Pulses once per stored word
    assign read_data_o    = mem[read_ptr]; // Head word, no read latency

    // ====================
    // Pointers and occupancy
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (do_write)
                write_ptr <= write_ptr + 1'b1; // DEPTH is a power of two
            if (do_read)
                read_ptr <= read_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_write)
            mem[write_ptr] <= write_data_i;
    end

endmodule

// File: source/uart_top.sv
module uart_top #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16,
    parameter int FIFO_DEPTH        = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rx_i,
    output logic                                tx_o,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] tx_data_i,
    input  logic                                tx_write_i,
    output logic                                tx_full_o,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] rx_data_o,
    output logic                                rx_valid_o,
    input  logic                                rx_read_i,
    output logic                                rx_frame_error_o,
    output logic                                rx_overflow_o
);

    logic                                   rx_ready;
    logic                                   rx_ack;
    logic                                   rx_fifo_full;
    logic [arch_defs_pkg::DATA_WIDTH-1:0]   rx_word;
    logic [arch_defs_pkg::STATUS_WIDTH-1:0] rx_status;
    logic                                   tx_word_available;
    logic                                   tx_take_word;
    logic [arch_defs_pkg::DATA_WIDTH-1:0]   tx_word;

    // ====================
    // Receive path
    // ====================
    uart_receiver #(
        .CLOCK_SPEED       (CLOCK_SPEED),
        .BAUD_RATE         (BAUD_RATE),
        .OVERSAMPLING_RATE (OVERSAMPLING_RATE),
        .WORD_SIZE         (arch_defs_pkg::DATA_WIDTH)
    ) receiver (
        .clk                        (clk),
        .reset                      (reset),
        .rx_serial_in_data          (rx_i),
        .cpu_read_data_ack_pulse    (rx_ack),
        .rx_strobe_data_ready_level (rx_ready),
        .rx_parallel_data_out       (rx_word),
        .rx_status_reg              (rx_status)
    );

    word_fifo #(
        .WIDTH (arch_defs_pkg::DATA_WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) rx_buffer (
        .clk            (clk),
        .reset          (reset),
        .write_i        (rx_ready),
        .write_data_i   (rx_word),
        .read_i         (rx_read_i),
        .read_data_o    (rx_data_o),
        .write_accept_o (rx_ack),       // Ack withheld while full
        .not_empty_o    (rx_valid_o),
        .full_o         (rx_fifo_full)
    );

    assign rx_frame_error_o = rx_status[arch_defs_pkg::STATUS_FRAME_ERROR_BIT];

    // A start bit while the receiver is stalled on a full FIFO is lost
    always_ff @(posedge clk) begin
        if (reset)
            rx_overflow_o <= 1'b0;
        else if (rx_fifo_full && rx_ready && !rx_i)
            rx_overflow_o <= 1'b1;
    end

    // ====================
    // Transmit path
    // ====================
    word_fifo #(
        .WIDTH (arch_defs_pkg::DATA_WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) tx_buffer (
        .clk            (clk),
        .reset          (reset),
        .write_i        (tx_write_i),
        .write_data_i   (tx_data_i),
        .read_i         (tx_take_word),
        .read_data_o    (tx_word),
        .write_accept_o (),
        .not_empty_o    (tx_word_available),
        .full_o         (tx_full_o)
    );

    uart_transmitter #(
        .CLOCK_SPEED       (CLOCK_SPEED),
        .BAUD_RATE         (BAUD_RATE),
        .OVERSAMPLING_RATE (OVERSAMPLING_RATE),
        .WORD_SIZE         (arch_defs_pkg::DATA_WIDTH)
    ) transmitter (
        .clk                 (clk),
        .reset               (reset),
        .tx_word_available_i (tx_word_available),
        .tx_word_i           (tx_word),
        .tx_take_word_o      (tx_take_word),
        .tx_serial_out_o     (tx_o),
        .tx_busy_o           ()
    );

endmodule

// File: testbench/tb_uart_top.sv
module tb_uart_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CYCLES = 160;  // 10 cycles per sample, 16 samples per bit
    localparam int FIFO_DEPTH = 4;
    localparam int FRAME_BITS = arch_defs_pkg::DATA_WIDTH + 2;
    localparam int WAIT_LIMIT = 8 * FRAME_BITS * BIT_CYCLES;

    // Levels a wait can block on
    localparam int RX_VALID    = 0;
    localparam int FRAME_ERROR = 1;
    localparam int TX_SPACE    = 2;
    localparam int RX_BUF_FULL = 3;

    typedef logic [arch_defs_pkg::DATA_WIDTH-1:0] word_t;

    logic  clk;
    logic  reset;
    logic  rx_line;
    logic  tx_o;
    word_t tx_data;
    logic  tx_write;
    logic  tx_full;
    word_t rx_data;
    logic  rx_valid;
    logic  rx_read;
    logic  rx_frame_error;
    logic  rx_overflow;
    logic  loopback_sel;   // 1 feeds tx_o back into rx_i
    logic  serial_drive;   // Line level from the frame model

    integer seed;
    int     errors;
    int     checks;

    assign rx_line = loopback_sel ? tx_o : serial_drive;

    uart_top #(
        .BAUD_RATE  (125_000),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk              (clk),
        .reset            (reset),
        .rx_i             (rx_line),
        .tx_o             (tx_o),
        .tx_data_i        (tx_data),
        .tx_write_i       (tx_write),
        .tx_full_o        (tx_full),
        .rx_data_o        (rx_data),
        .rx_valid_o       (rx_valid),
        .rx_read_i        (rx_read),
        .rx_frame_error_o (rx_frame_error),
        .rx_overflow_o    (rx_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================
    // Compare and wait helpers
    // ====================
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    function automatic logic level_of(input int which);
        case (which)
            RX_VALID:    return rx_valid;
            FRAME_ERROR: return rx_frame_error;
            TX_SPACE:    return !tx_full;
            default:     return DUT.rx_buffer.full_o;
        endcase
    endfunction

    task automatic wait_for_level(input int which, input string what);
        int cycles;
        cycles = 0;
        while (level_of(which) !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (level_of(which) !== 1'b1) begin
            errors++;
            $display("timeout waiting for %s", what);
        end
    endtask

    function automatic word_t random_byte();
        int value;
        value = $random(seed);
        return value[arch_defs_pkg::DATA_WIDTH-1:0];
    endfunction

    // ====================
    // Bus and line drivers
    // ====================
    task automatic write_tx(input word_t data);
        wait_for_level(TX_SPACE, "tx_full_o to fall");
        tx_data  = data;
        tx_write = 1'b1;
        @(negedge clk);
        tx_write = 1'b0;
    endtask

    task automatic read_rx(input string name, input word_t expected);
        wait_for_level(RX_VALID, "rx_valid_o");
        check_word(name, expected, rx_data);
        rx_read = 1'b1;
        @(negedge clk);
        rx_read = 1'b0;
    endtask

    // Start bit, data LSB first, then stop bit
    task automatic send_serial_frame(input word_t data, input logic bad_stop);
        logic [FRAME_BITS-1:0] frame;
        frame = {~bad_stop, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            serial_drive = frame[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        serial_drive = 1'b1;
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_reset_state();
        check_flag("test_reset_state tx_o", 1'b1, tx_o);
        check_flag("test_reset_state rx_valid_o", 1'b0, rx_valid);
        check_flag("test_reset_state rx_frame_error_o", 1'b0, rx_frame_error);
        check_flag("test_reset_state rx_overflow_o", 1'b0, rx_overflow);
        check_flag("test_reset_state tx_full_o", 1'b0, tx_full);
    endtask

    task automatic test_loopback();
        word_t data;
        loopback_sel = 1'b1;
        for (int i = 0; i < 4; i++) begin
            data = random_byte();
            write_tx(data);
            read_rx("test_loopback", data);
        end
    endtask

    task automatic test_order();
        word_t sent [$];
        loopback_sel = 1'b1;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            sent.push_back(random_byte());
            write_tx(sent[i]);
        end
        wait_for_level(RX_BUF_FULL, "receive FIFO to fill");
        for (int i = 0; i < FIFO_DEPTH; i++)
            read_rx("test_order", sent[i]);
        check_flag("test_order rx_overflow_o", 1'b0, rx_overflow);
    endtask

    task automatic test_frame_error();
        word_t data;
        loopback_sel = 1'b0;
        send_serial_frame(random_byte(), 1'b1);
        wait_for_level(FRAME_ERROR, "rx_frame_error_o");
        repeat (BIT_CYCLES) @(negedge clk);   // Idle gap before the next frame
        check_flag("test_frame_error flag", 1'b1, rx_frame_error);
        check_flag("test_frame_error no word", 1'b0, rx_valid);
        data = random_byte();
        send_serial_frame(data, 1'b0);
        read_rx("test_frame_error recovery", data);
        check_flag("test_frame_error cleared", 1'b0, rx_frame_error);
    endtask

    task automatic test_false_start();
        word_t data;
        loopback_sel = 1'b0;
        serial_drive = 1'b0;
        repeat (BIT_CYCLES / 4) @(negedge clk);
        serial_drive = 1'b1;
        repeat (FRAME_BITS * BIT_CYCLES) @(negedge clk);  // Longer than a whole frame
        check_flag("test_false_start no word", 1'b0, rx_valid);
        data = random_byte();
        send_serial_frame(data, 1'b0);
        read_rx("test_false_start", data);
    endtask

    task automatic test_overflow();
        word_t sent [$];
        loopback_sel = 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            sent.push_back(random_byte());
            send_serial_frame(sent[i], 1'b0);
        end
        check_flag("test_overflow rx_overflow_o", 1'b1, rx_overflow);
        for (int i = 0; i < FIFO_DEPTH; i++)
            read_rx("test_overflow", sent[i]);
    endtask

    initial begin
        seed         = 32'hd9f9;
        errors       = 0;
        checks       = 0;
        reset        = 1'b1;
        loopback_sel = 1'b0;
        serial_drive = 1'b1;   // Line idles high
        tx_data      = '0;
        tx_write     = 1'b0;
        rx_read      = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_reset_state();
        test_loopback();
        test_order();
        test_frame_error();
        test_false_start();
        test_overflow();   // Leaves words behind, so it runs last

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: uart.f
source/arch_defs_pkg.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/word_fifo.sv
source/uart_top.sv
testbench/tb_uart_top.sv

// File: Makefile
SIM     := obj_dir/Vtb_uart_top
SOURCES := $(filter-out +%,$(shell cat uart.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): uart.f $(SOURCES)
	verilator --binary --timing --top-module tb_uart_top -f uart.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
